// ==== hdl/coef_arith_engine.sv ====
// Operands must already be below q and are not range-checked, and opcode 3 computes a multiply
`timescale 1ns/1ps

module coef_arith_engine
    import mldsa_arith_pkg::*;
(
    input  logic    crypt_clk,
    input  logic    resetn,
    input  op_req_t op_i,
    input  logic    op_req_i,
    output logic    op_ack_o,
    output coef_t   result_o,
    output logic    res_req_o,
    input  logic    res_ack_i,
    output logic    trigger_o
);

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        PRESENT,
        WAIT_DROP
    } eng_state_e;

    eng_state_e  state_q;
    logic [1:0]  step_q;
    logic        op_ack_q;
    logic        accept;
    logic        last_step;
    op_req_t     op_q;
    prod_t       s1_d;
    prod_t       s1_q;
    logic [35:0] fold1;        // Below 2^36 after the first fold
    logic [26:0] s2_d;         // Below 2^27 after the second fold
    logic [26:0] s2_q;
    logic [23:0] fold3;        // Below 2q after the last fold
    coef_t       s3_d;
    coef_t       result_q;

    assign accept    = (state_q == IDLE) && op_req_i && !op_ack_q;
    assign last_step = (step_q == 2'(PIPE_STAGES - 1));

    // --------------------------------------------------
    // Three datapath stages after the operand latch
    // --------------------------------------------------
    always_comb begin
        case (op_q.op)
            OP_ADD:  s1_d = prod_t'(op_q.a) + prod_t'(op_q.b);
            OP_SUB:  s1_d = prod_t'(op_q.a) + prod_t'(MLDSA_Q) - prod_t'(op_q.b);
            default: s1_d = prod_t'(op_q.a) * prod_t'(op_q.b);
        endcase
    end

    // x = hi*2^23 + lo folds to hi*2^13 - hi + lo
    always_comb begin
        fold1 = {s1_q[2*COEF_W-1:COEF_W], {FOLD_SH{1'b0}}}
                - 36'(s1_q[2*COEF_W-1:COEF_W]) + 36'(s1_q[COEF_W-1:0]);
        s2_d  = 27'({fold1[35:COEF_W], {FOLD_SH{1'b0}}})
                - 27'(fold1[35:COEF_W]) + 27'(fold1[COEF_W-1:0]);
    end

    // Small fold then a single subtraction covers the range below 2q
    always_comb begin
        fold3 = 24'({s2_q[26:COEF_W], {FOLD_SH{1'b0}}})
                - 24'(s2_q[26:COEF_W]) + 24'(s2_q[COEF_W-1:0]);
        s3_d  = (fold3 >= 24'(MLDSA_Q)) ? coef_t'(fold3 - 24'(MLDSA_Q)) : coef_t'(fold3);
    end

    always_ff @(posedge crypt_clk) begin
        if (accept) begin
            op_q <= op_i;
        end
        if (state_q == COMPUTE) begin
            s1_q <= s1_d;
            s2_q <= s2_d;
        end
        if ((state_q == COMPUTE) && last_step) begin
            result_q <= s3_d;                   // Held through PRESENT
        end
    end

    // --------------------------------------------------
    // Control FSM and handshakes
    // --------------------------------------------------
    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            state_q  <= IDLE;
            step_q   <= '0;
            op_ack_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= COMPUTE;
                        step_q  <= '0;
                    end
                end
                COMPUTE: begin
                    if (last_step) begin
                        state_q <= PRESENT;     // Result req three cycles after ack
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                PRESENT:   if (res_ack_i) state_q <= WAIT_DROP;
                WAIT_DROP: if (!res_ack_i) state_q <= IDLE;
                default:   state_q <= IDLE;
            endcase

            if (accept) begin
                op_ack_q <= 1'b1;
            end else if (op_ack_q && !op_req_i) begin
                op_ack_q <= 1'b0;               // Sender has dropped req
            end
        end
    end

    assign op_ack_o  = op_ack_q;
    assign result_o  = result_q;
    assign res_req_o = (state_q == PRESENT);
    assign trigger_o = (state_q == COMPUTE);   // Capture window

endmodule

// ==== hdl/host_reg_pkg.sv ====
// Host register map for byte writes where byte count 3 is outside every operand
package host_reg_pkg;

    // --------------------------------------------------
    // Address and byte-count widths
    // --------------------------------------------------
    localparam int REG_ADDR_W = 5;
    localparam int BYTECNT_W = 2;
    localparam int REG_BYTE_W = 8;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [BYTECNT_W-1:0]  bytecnt_t;
    typedef logic [REG_BYTE_W-1:0] reg_byte_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam reg_addr_t REG_OPA = 5'd0;   // Operand a in bytes 0..2
    localparam reg_addr_t REG_OPB = 5'd1;   // Operand b in bytes 0..2
    localparam reg_addr_t REG_GO  = 5'd2;   // Opcode in bits 1:0

    // Opcode field inside the GO data byte
    localparam int GO_OP_LSB = 0;
    localparam int GO_OP_MSB = 1;

    // One host write of 15 bits
    typedef struct packed {
        reg_addr_t addr;
        bytecnt_t  bytecnt;
        reg_byte_t data;
    } host_wr_t;

endpackage

// ==== hdl/host_word_assembler.sv ====
// GO writes are dropped while a request is in flight and opcode 3 is undefined (computed as a multiply)
`timescale 1ns/1ps

module host_word_assembler
    import mldsa_arith_pkg::*;
    import host_reg_pkg::*;
(
    input  logic     crypt_clk,
    input  logic     resetn,
    input  host_wr_t host_wr_i,
    input  logic     host_wr_en_i,
    output op_req_t  op_o,
    output logic     op_req_o,
    input  logic     op_ack_i,
    output logic     busy_o,
    output logic     drop_o
);

    typedef enum logic {
        IDLE,
        OFFER
    } asm_state_e;

    asm_state_e state_q;
    coef_t      opa_q;
    coef_t      opb_q;
    op_req_t    op_q;       // Private copy while offered
    logic       drop_q;
    logic       go_wr;
    logic       go_ok;

    // Places one host byte into its lane of a coefficient
    function automatic coef_t put_byte(coef_t cur, bytecnt_t lane, reg_byte_t data);
        coef_t upd;
        upd = cur;
        case (lane)
            2'd0:    upd[7:0]   = data;
            2'd1:    upd[15:8]  = data;
            2'd2:    upd[22:16] = data[6:0];   // Top bit of the byte is unused
            default: upd        = cur;
        endcase
        return upd;
    endfunction

    assign go_wr = host_wr_en_i && (host_wr_i.addr == REG_GO);
    assign go_ok = (state_q == IDLE) && !op_ack_i;    // Previous ack must have fallen

    // --------------------------------------------------
    // Operand staging registers
    // --------------------------------------------------
    always_ff @(posedge crypt_clk) begin
        if (host_wr_en_i && (host_wr_i.addr == REG_OPA)) begin
            opa_q <= put_byte(opa_q, host_wr_i.bytecnt, host_wr_i.data);
        end
        if (host_wr_en_i && (host_wr_i.addr == REG_OPB)) begin
            opb_q <= put_byte(opb_q, host_wr_i.bytecnt, host_wr_i.data);
        end
        if (go_wr && go_ok) begin
            op_q.op <= arith_op_e'(host_wr_i.data[GO_OP_MSB:GO_OP_LSB]);
            op_q.a  <= opa_q;
            op_q.b  <= opb_q;
        end
    end

    // --------------------------------------------------
    // Request handshake and drop flag
    // --------------------------------------------------
    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= IDLE;
            drop_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (go_wr && go_ok) begin
                        state_q <= OFFER;
                    end
                end
                OFFER: begin
                    if (op_ack_i) begin
                        state_q <= IDLE;        // req falls next cycle
                    end
                end
                default: state_q <= IDLE;
            endcase
            if (go_wr && !go_ok) begin
                drop_q <= 1'b1;                 // Sticky until reset
            end
        end
    end

    assign op_o     = op_q;
    assign op_req_o = (state_q == OFFER);
    assign busy_o   = (state_q == OFFER) || op_ack_i;
    assign drop_o   = drop_q;

endmodule

// ==== hdl/mldsa_arith_pkg.sv ====
// Coefficient types and constants for q = 8380417 where operands are assumed already below q
package mldsa_arith_pkg;

    // --------------------------------------------------
    // Modulus and derived widths
    // --------------------------------------------------
    localparam int COEF_W = 23;
    localparam int FOLD_SH = 13;                        // 2^23 == 2^13 - 1 (mod q)
    localparam logic [COEF_W-1:0] MLDSA_Q = 23'd8380417;
    localparam int PIPE_STAGES = 3;                     // Engine cycles from ack to result

    // Operation queue and LED hold time
    localparam int OP_FIFO_PTR_W = 2;
    localparam int OP_FIFO_DEPTH = 2 ** OP_FIFO_PTR_W;
    localparam int LED_CNT_W = 24;
    localparam logic [LED_CNT_W-1:0] LED_HOLD_CYCLES = 24'd10000000;

    typedef logic [COEF_W-1:0]        coef_t;
    typedef logic [2*COEF_W-1:0]      prod_t;           // Unreduced a*b
    typedef logic [OP_FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [OP_FIFO_PTR_W:0]   fifo_cnt_t;       // Holds 0 up to the full depth
    typedef logic [LED_CNT_W-1:0]     led_cnt_t;

    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2
    } arith_op_e;

    // One queued operation of 48 bits
    typedef struct packed {
        arith_op_e op;
        coef_t     a;
        coef_t     b;
    } op_req_t;

endpackage

// ==== hdl/mldsa_harness_top.sv ====
// Single-clock harness and result_o is valid only while res_req_o is high
`timescale 1ns/1ps

module mldsa_harness_top
    import mldsa_arith_pkg::*;
    import host_reg_pkg::*;
(
    input  logic     crypt_clk,
    input  logic     resetn,
    input  host_wr_t host_wr_i,
    input  logic     host_wr_en_i,
    output logic     busy_o,
    output logic     drop_o,
    output coef_t    result_o,
    output logic     res_req_o,
    input  logic     res_ack_i,
    output logic     trigger_o,
    output logic     led_o
);

    op_req_t asm_op;        // Assembler to queue
    logic    asm_req;
    logic    asm_ack;
    op_req_t eng_op;        // Queue to engine
    logic    eng_req;
    logic    eng_ack;
    logic    trigger;

    // --------------------------------------------------
    // Producer, buffer, consumer
    // --------------------------------------------------
    host_word_assembler i_host_word_assembler (
        .crypt_clk    (crypt_clk),
        .resetn       (resetn),
        .host_wr_i    (host_wr_i),
        .host_wr_en_i (host_wr_en_i),
        .op_o         (asm_op),
        .op_req_o     (asm_req),
        .op_ack_i     (asm_ack),
        .busy_o       (busy_o),
        .drop_o       (drop_o)
    );

    op_fifo i_op_fifo (
        .crypt_clk (crypt_clk),
        .resetn    (resetn),
        .in_op_i   (asm_op),
        .in_req_i  (asm_req),
        .in_ack_o  (asm_ack),
        .out_op_o  (eng_op),
        .out_req_o (eng_req),
        .out_ack_i (eng_ack)
    );

    coef_arith_engine i_coef_arith_engine (
        .crypt_clk (crypt_clk),
        .resetn    (resetn),
        .op_i      (eng_op),
        .op_req_i  (eng_req),
        .op_ack_o  (eng_ack),
        .result_o  (result_o),
        .res_req_o (res_req_o),
        .res_ack_i (res_ack_i),
        .trigger_o (trigger)
    );

    // Trigger goes to the scope pin and the LED
    trigger_led_timer i_trigger_led_timer (
        .crypt_clk (crypt_clk),
        .resetn    (resetn),
        .trigger_i (trigger),
        .led_o     (led_o)
    );

    assign trigger_o = trigger;

endmodule

// ==== hdl/op_fifo.sv ====
// Four-entry operation queue where the input side holds ack low while every slot is taken
`timescale 1ns/1ps

module op_fifo
    import mldsa_arith_pkg::*;
(
    input  logic    crypt_clk,
    input  logic    resetn,
    input  op_req_t in_op_i,
    input  logic    in_req_i,
    output logic    in_ack_o,
    output op_req_t out_op_o,
    output logic    out_req_o,
    input  logic    out_ack_i
);

    typedef enum logic {
        IN_WAIT_REQ,
        IN_WAIT_DROP
    } in_state_e;

    typedef enum logic {
        OUT_OFFER,
        OUT_WAIT_DROP
    } out_state_e;

    op_req_t    mem_q [OP_FIFO_DEPTH];
    fifo_ptr_t  wr_ptr_q;
    fifo_ptr_t  rd_ptr_q;
    fifo_cnt_t  count_q;
    in_state_e  in_state_q;
    out_state_e out_state_q;
    logic       out_req_q;
    logic       full;
    logic       push;
    logic       pop;

    assign full = (count_q == fifo_cnt_t'(OP_FIFO_DEPTH));
    assign push = (in_state_q == IN_WAIT_REQ) && in_req_i && !full;
    assign pop  = (out_state_q == OUT_OFFER) && out_req_q && out_ack_i;

    // Storage written only on an accepted request
    always_ff @(posedge crypt_clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_op_i;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at the depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // --------------------------------------------------
    // Handshake machines for the two sides
    // --------------------------------------------------
    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            in_state_q  <= IN_WAIT_REQ;
            out_state_q <= OUT_OFFER;
            out_req_q   <= 1'b0;
        end else begin
            case (in_state_q)
                IN_WAIT_REQ:  if (push) in_state_q <= IN_WAIT_DROP;
                IN_WAIT_DROP: if (!in_req_i) in_state_q <= IN_WAIT_REQ;
                default:      in_state_q <= IN_WAIT_REQ;
            endcase

            case (out_state_q)
                OUT_OFFER: begin
                    if (pop) begin
                        out_req_q   <= 1'b0;
                        out_state_q <= OUT_WAIT_DROP;
                    end else if (count_q != '0) begin
                        out_req_q <= 1'b1;      // One cycle after non-empty
                    end
                end
                OUT_WAIT_DROP: begin
                    if (!out_ack_i) begin
                        out_state_q <= OUT_OFFER;
                    end
                end
                default: out_state_q <= OUT_OFFER;
            endcase
        end
    end

    assign in_ack_o  = (in_state_q == IN_WAIT_DROP);
    assign out_op_o  = mem_q[rd_ptr_q];     // Head stays put until popped
    assign out_req_o = out_req_q;

endmodule

// ==== hdl/trigger_led_timer.sv ====
// LED stays lit for LED_HOLD_CYCLES after the last trigger cycle and each trigger reloads it
`timescale 1ns/1ps

module trigger_led_timer
    import mldsa_arith_pkg::*;
(
    input  logic crypt_clk,
    input  logic resetn,
    input  logic trigger_i,
    output logic led_o
);

    led_cnt_t cnt_q;

    // --------------------------------------------------
    // Hold counter
    // --------------------------------------------------
    always_ff @(posedge crypt_clk or negedge resetn) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (trigger_i) begin
            cnt_q <= LED_HOLD_CYCLES;           // Restart on every trigger cycle
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - led_cnt_t'(1);
        end
    end

    // Lit while any count remains
    assign led_o = (cnt_q != '0);

endmodule

// ==== mldsa_harness.f ====
hdl/mldsa_arith_pkg.sv
hdl/host_reg_pkg.sv
hdl/host_word_assembler.sv
hdl/op_fifo.sv
hdl/coef_arith_engine.sv
hdl/trigger_led_timer.sv
hdl/mldsa_harness_top.sv
verification/mldsa_harness_assert.sv
verification/tb_mldsa_harness.sv

// ==== verification/mldsa_harness_assert.sv ====
// Bound into mldsa_harness_top and expects the engine's fixed three-cycle pipeline after each ack
`timescale 1ns/1ps

module mldsa_harness_assert
    import mldsa_arith_pkg::*;
(
    input logic  crypt_clk,
    input logic  resetn,
    input logic  asm_req_i,
    input logic  asm_ack_i,
    input logic  eng_req_i,
    input logic  eng_ack_i,
    input logic  res_req_i,
    input logic  res_ack_i,
    input coef_t result_i,
    input logic  busy_i,
    input logic  drop_i,
    input logic  trigger_i,
    input logic  led_i
);

    int fail_cnt = 0;       // Failed assertions so far

    // Four-phase rule where req stays up until ack
    property req_holds(req, ack);
        @(posedge crypt_clk) disable iff (!resetn) (req && !ack) |=> req;
    endproperty

    // --------------------------------------------------
    // Handshake links
    // --------------------------------------------------
    a_asm_req_hold: assert property (req_holds(asm_req_i, asm_ack_i))
        else begin
            fail_cnt++;
            $error("Assembler req fell before the FIFO ack");
        end

    a_eng_req_hold: assert property (req_holds(eng_req_i, eng_ack_i))
        else begin
            fail_cnt++;
            $error("FIFO req fell before the engine ack");
        end

    a_res_req_hold: assert property (req_holds(res_req_i, res_ack_i))
        else begin
            fail_cnt++;
            $error("Result req fell before the external ack");
        end

    // --------------------------------------------------
    // Result range and pipeline latency
    // --------------------------------------------------
    a_result_range: assert property (@(posedge crypt_clk) disable iff (!resetn)
        res_req_i |-> (result_i < MLDSA_Q))
        else begin
            fail_cnt++;
            $error("Result %0d is not below q", result_i);
        end

    a_result_latency: assert property (@(posedge crypt_clk) disable iff (!resetn)
        $rose(eng_ack_i) |-> !res_req_i [*3] ##1 res_req_i)
        else begin
            fail_cnt++;
            $error("Result req did not follow the engine ack by three cycles");
        end

    // Everything quiet while reset is held
    a_reset_quiet: assert property (@(posedge crypt_clk)
        !resetn |-> !(busy_i || drop_i || res_req_i || trigger_i || led_i
                      || asm_req_i || asm_ack_i || eng_req_i || eng_ack_i))
        else begin
            fail_cnt++;
            $error("A control output is high during reset");
        end

endmodule

bind mldsa_harness_top mldsa_harness_assert i_harness_assert (
    .crypt_clk (crypt_clk),
    .resetn    (resetn),
    .asm_req_i (asm_req),
    .asm_ack_i (asm_ack),
    .eng_req_i (eng_req),
    .eng_ack_i (eng_ack),
    .res_req_i (res_req_o),
    .res_ack_i (res_ack_i),
    .result_i  (result_o),
    .busy_i    (busy_o),
    .drop_i    (drop_o),
    .trigger_i (trigger_o),
    .led_i     (led_o)
);

// ==== verification/tb_mldsa_harness.sv ====
// Operands are always drawn below q and a stuck handshake ends the run through the watchdog
`timescale 1ns/1ps

module tb_mldsa_harness
    import mldsa_arith_pkg::*;
    import host_reg_pkg::*;
();

    localparam logic [31:0] SEED = 32'h0be5_2bb7;
    localparam int N_OPS = 225;                         // Directed, random, back-pressure, reset
    localparam longint TIMEOUT_NS = (longint'(N_OPS) * 200 + 1000) * 40;

    logic     crypt_clk = 1'b0;
    logic     resetn;
    host_wr_t host_wr_i;
    logic     host_wr_en_i;
    logic     busy_o;
    logic     drop_o;
    coef_t    result_o;
    logic     res_req_o;
    logic     res_ack_i;
    logic     trigger_o;
    logic     led_o;

    coef_t       exp_q[$];      // Expected results in issue order
    string       test_name = "reset_init";
    logic [31:0] rng_state;
    logic [31:0] resp_state;
    bit          hold_ack;
    bit          rand_delay;
    int          check_errs = 0;
    int          other_errs = 0;
    int          trig_run = 0;
    bit          trig_prev = 1'b0;

    mldsa_harness_top i_mldsa_harness_top (.*);

    always #20 crypt_clk = ~crypt_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // (a op b) mod q in wide arithmetic
    function automatic coef_t mod_q_result(input arith_op_e op, input coef_t a, input coef_t b);
        longint unsigned q;
        longint unsigned x;
        q = longint'(MLDSA_Q);
        case (op)
            OP_ADD:  x = (longint'(a) + longint'(b)) % q;
            OP_SUB:  x = (longint'(a) + q - longint'(b)) % q;
            default: x = (longint'(a) * longint'(b)) % q;
        endcase
        return coef_t'(x);
    endfunction

    // --------------------------------------------------
    // Host write tasks
    // --------------------------------------------------
    task automatic write_reg(input reg_addr_t addr, input bytecnt_t cnt, input reg_byte_t data);
        @(posedge crypt_clk);
        #2;
        host_wr_i.addr    = addr;
        host_wr_i.bytecnt = cnt;
        host_wr_i.data    = data;
        host_wr_en_i      = 1'b1;
    endtask

    task automatic wait_not_busy();
        while (busy_o) begin
            @(posedge crypt_clk);
            #2;
        end
    endtask

    // Accepted ops wait for a free assembler and are added to the model
    task automatic issue_op(input arith_op_e op, input coef_t a, input coef_t b,
                            input bit accepted);
        if (accepted) wait_not_busy();
        for (int i = 0; i < 3; i++) write_reg(REG_OPA, bytecnt_t'(i), reg_byte_t'(a >> (8 * i)));
        for (int i = 0; i < 3; i++) write_reg(REG_OPB, bytecnt_t'(i), reg_byte_t'(b >> (8 * i)));
        write_reg(REG_GO, '0, {6'd0, op});
        @(posedge crypt_clk);
        #2;
        host_wr_en_i = 1'b0;
        if (accepted) exp_q.push_back(mod_q_result(op, a, b));
    endtask

    task automatic issue_random(input bit accepted);
        arith_op_e op;
        coef_t     a;
        coef_t     b;
        op = arith_op_e'(2'(next_rand() % 3));
        a  = coef_t'(next_rand() % MLDSA_Q);
        b  = coef_t'(next_rand() % MLDSA_Q);
        issue_op(op, a, b, accepted);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge crypt_clk);
        while (res_req_o || res_ack_i) @(posedge crypt_clk);
        #2;
    endtask

    task automatic set_hold(input bit hold);
        @(negedge crypt_clk);
        hold_ack = hold;
    endtask

    // --------------------------------------------------
    // Result responder and reference check
    // --------------------------------------------------
    always begin : responder
        coef_t exp_val;
        int    delay;
        @(posedge crypt_clk);
        #2;
        if (resetn && res_req_o && !hold_ack) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Result %0d arrived with no operation pending", result_o);
            end else begin
                exp_val = exp_q.pop_front();
                assert (result_o === exp_val) else begin
                    check_errs++;
                    $display("CHECK FAILED test=%s expected=%0d actual=%0d",
                             test_name, exp_val, result_o);
                end
            end
            resp_state = xorshift32(resp_state);
            delay      = rand_delay ? int'(resp_state % 8) : 1;
            repeat (delay) @(posedge crypt_clk);
            #2;
            res_ack_i = 1'b1;
            while (res_req_o && resetn) begin
                @(posedge crypt_clk);
                #2;
            end
            res_ack_i = 1'b0;
        end
    end

    // Trigger width and LED follow-up
    always @(negedge crypt_clk) begin
        if (!resetn) begin
            trig_run  = 0;
            trig_prev = 1'b0;
        end else begin
            if (trigger_o) begin
                trig_run++;
            end else if (trig_run != 0) begin
                assert (trig_run == 3) else begin
                    check_errs++;
                    $display("CHECK FAILED test=trigger_led expected=3 actual=%0d", trig_run);
                end
                trig_run = 0;
            end
            if (trig_prev) begin
                assert (led_o === 1'b1) else begin
                    check_errs++;
                    $display("CHECK FAILED test=trigger_led expected=1 actual=%b", led_o);
                end
            end
            trig_prev = trigger_o;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the watchdog expired before all operations completed");
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin : stimulus
        int assert_errs;
        host_wr_i    = '0;
        host_wr_en_i = 1'b0;
        res_ack_i    = 1'b0;
        hold_ack     = 1'b0;
        rand_delay   = 1'b0;
        rng_state    = SEED;
        resp_state   = SEED;
        resetn       = 1'b1;
        #5 resetn = 1'b0;
        repeat (8) @(posedge crypt_clk);
        #2 resetn = 1'b1;

        test_name = "directed";
        issue_op(OP_MUL, MLDSA_Q - 1, MLDSA_Q - 1, 1'b1);   // Gives 1
        issue_op(OP_MUL, 23'd0, MLDSA_Q - 1, 1'b1);
        issue_op(OP_MUL, 23'd1, MLDSA_Q - 1, 1'b1);
        issue_op(OP_MUL, 23'd1234567, 23'd7654321, 1'b1);
        issue_op(OP_ADD, MLDSA_Q - 1, MLDSA_Q - 1, 1'b1);
        issue_op(OP_ADD, MLDSA_Q - 1, 23'd1, 1'b1);         // Wraps to 0
        issue_op(OP_ADD, 23'd0, 23'd0, 1'b1);
        issue_op(OP_SUB, 23'd0, 23'd1, 1'b1);
        issue_op(OP_SUB, 23'd0, 23'd0, 1'b1);
        issue_op(OP_SUB, 23'd5, 23'd3, 1'b1);
        issue_op(OP_SUB, 23'd1, MLDSA_Q - 1, 1'b1);
        wait_drain();

        test_name  = "random";
        rand_delay = 1'b1;
        repeat (200) issue_random(1'b1);
        wait_drain();

        // One computing, four queued, one held in the assembler
        test_name  = "backpressure";
        rand_delay = 1'b0;
        set_hold(1'b1);
        repeat (6) issue_random(1'b1);
        issue_op(OP_ADD, 23'd7, 23'd9, 1'b0);
        assert (drop_o === 1'b1) else begin
            check_errs++;
            $display("CHECK FAILED test=%s expected=1 actual=%b", test_name, drop_o);
        end
        set_hold(1'b0);
        wait_drain();

        // Engine, FIFO and assembler all occupied when reset hits
        test_name = "reset";
        set_hold(1'b1);
        repeat (6) issue_random(1'b1);
        while (!res_req_o) @(posedge crypt_clk);
        @(posedge crypt_clk);
        #2 resetn = 1'b0;
        @(negedge crypt_clk);
        assert ({busy_o, drop_o, res_req_o, trigger_o} === 4'b0000) else begin
            check_errs++;
            $display("CHECK FAILED test=%s expected=0000 actual=%b", test_name,
                     {busy_o, drop_o, res_req_o, trigger_o});
        end
        repeat (8) @(posedge crypt_clk);
        #2 resetn = 1'b1;
        exp_q.delete();
        set_hold(1'b0);
        repeat (20) @(posedge crypt_clk);               // A stale result would show up here
        issue_op(OP_SUB, 23'd3, 23'd5, 1'b1);
        wait_drain();

        assert_errs = i_mldsa_harness_top.i_harness_assert.fail_cnt;
        $display("Errors: %0d value checks, %0d other, %0d assertions",
                 check_errs, other_errs, assert_errs);
        if (check_errs + other_errs + assert_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
